//--- logic/cbfp2_pkg.sv
package cbfp2_pkg;

   ////////////////////
   // Lane geometry
   ////////////////////

   localparam int LANES           = 32;  // Complex samples per pop
   localparam int GROUPS          = 4;   // Stage 1 factors per push
   localparam int GROUP_LANES     = 8;   // Lanes covered by one stage 1 factor
   localparam int POPS_PER_STAGE0 = 2;   // 64 samples over 32 lanes

   ////////////////////
   // Widths
   ////////////////////

   localparam int SAMPLE_W = 16;
   localparam int OUT_W    = 13;
   localparam int FACTOR_W = 5;
   localparam int EXP_W    = 6;   // Sum of two factors

   ////////////////////
   // Factor stores
   ////////////////////

   localparam int STORE_DEPTH  = 64;
   localparam int STORE_ADDR_W = 6;

   ////////////////////
   // Renormalization
   ////////////////////

   // Exponent with no shift applied
   localparam int NORM_POINT = 9;

   // At and above this the sample is flushed to zero
   localparam int ZERO_LIMIT = 23;

   ////////////////////
   // Types
   ////////////////////

   typedef logic signed [SAMPLE_W-1:0] sample_t;
   typedef logic signed [OUT_W-1:0]    out_sample_t;

   typedef logic [FACTOR_W-1:0] factor_t;
   typedef logic [EXP_W-1:0]    exponent_t;

endpackage

//--- logic/stage0_factor_store.sv
`timescale 1ns/1ns

module stage0_factor_store (
   input  logic               clk,
   input  logic               rst_n,
   input  logic               push_idx1,
   input  cbfp2_pkg::factor_t push_data_idx1,
   input  logic               pop,
   output cbfp2_pkg::factor_t factor0
);

   import cbfp2_pkg::*;

   factor_t                 mem [STORE_DEPTH];
   logic [STORE_ADDR_W-1:0] wr_ptr;
   logic [STORE_ADDR_W-1:0] rd_ptr;
   logic [STORE_ADDR_W:0]   count;
   logic                    phase;  // Which pop of the pair is next
   logic                    do_push;
   logic                    do_read;
   logic                    phase_step;

   assign do_push = push_idx1 && (count != STORE_DEPTH);  // Full store drops the push

   // Only the first pop of a pair touches the queue
   assign do_read = pop && (phase == 1'b0) && (count != '0);

   // Second pop of a pair never needs an entry
   assign phase_step = do_read || (pop && (phase != 1'b0));

   always_ff @(posedge clk) begin
      if (do_push) begin
         mem[wr_ptr] <= push_data_idx1;
      end
   end

   always_ff @(posedge clk) begin
      if (!rst_n) begin
         wr_ptr  <= '0;
         rd_ptr  <= '0;
         count   <= '0;
         phase   <= 1'b0;
         factor0 <= '0;
      end else begin
         if (do_push) begin
            wr_ptr <= wr_ptr + 1'b1;
         end

         if (do_read) begin
            factor0 <= mem[rd_ptr];  // Held for the whole pair
            rd_ptr  <= rd_ptr + 1'b1;
         end

         if (phase_step) begin
            if (phase == 1'(POPS_PER_STAGE0 - 1)) begin
               phase <= 1'b0;
            end else begin
               phase <= phase + 1'b1;
            end
         end

         case ({do_push, do_read})
            2'b10:   count <= count + 1'b1;
            2'b01:   count <= count - 1'b1;
            default: count <= count;
         endcase
      end
   end

endmodule

//--- logic/stage1_factor_store.sv
`timescale 1ns/1ns

module stage1_factor_store (
   input  logic               clk,
   input  logic               rst_n,
   input  logic               push_idx2,
   input  cbfp2_pkg::factor_t push_data_idx2 [cbfp2_pkg::GROUPS],
   input  logic               pop,
   output cbfp2_pkg::factor_t factor1 [cbfp2_pkg::GROUPS]
);

   import cbfp2_pkg::*;

   // One entry per pop, four group factors wide
   factor_t                 mem [STORE_DEPTH][GROUPS];
   logic [STORE_ADDR_W-1:0] wr_ptr;
   logic [STORE_ADDR_W-1:0] rd_ptr;
   logic [STORE_ADDR_W:0]   count;
   logic                    do_push;
   logic                    do_read;

   assign do_push = push_idx2 && (count != STORE_DEPTH);
   assign do_read = pop && (count != '0);  // Empty pop holds the output

   ////////////////////
   // Quadruple storage
   ////////////////////

   always_ff @(posedge clk) begin
      if (do_push) begin
         for (int g = 0; g < GROUPS; g++) begin
            mem[wr_ptr][g] <= push_data_idx2[g];
         end
      end
   end

   ////////////////////
   // Pointers and head register
   ////////////////////

   always_ff @(posedge clk) begin
      if (!rst_n) begin
         wr_ptr <= '0;
         rd_ptr <= '0;
         count  <= '0;
         for (int g = 0; g < GROUPS; g++) begin
            factor1[g] <= '0;
         end
      end else begin
         if (do_push) begin
            wr_ptr <= wr_ptr + 1'b1;
         end

         if (do_read) begin
            for (int g = 0; g < GROUPS; g++) begin
               factor1[g] <= mem[rd_ptr][g];
            end
            rd_ptr <= rd_ptr + 1'b1;
         end

         // Simultaneous push and read leaves occupancy alone
         case ({do_push, do_read})
            2'b10:   count <= count + 1'b1;
            2'b01:   count <= count - 1'b1;
            default: count <= count;
         endcase
      end
   end

endmodule

//--- logic/exponent_sum.sv
`timescale 1ns/1ns

module exponent_sum (
   input  logic                 clk,
   input  logic                 rst_n,
   input  logic                 pop,
   input  cbfp2_pkg::factor_t   factor0,
   input  cbfp2_pkg::factor_t   factor1 [cbfp2_pkg::GROUPS],
   output cbfp2_pkg::exponent_t exponent [cbfp2_pkg::LANES]
);

   import cbfp2_pkg::*;

   logic pop_d;  // Store outputs settle one edge after pop

   always_ff @(posedge clk) begin
      if (!rst_n) begin
         pop_d <= 1'b0;
      end else begin
         pop_d <= pop;
      end
   end

   // Exponents hold between pops
   always_ff @(posedge clk) begin
      if (!rst_n) begin
         for (int l = 0; l < LANES; l++) begin
            exponent[l] <= '0;
         end
      end else if (pop_d) begin
         for (int l = 0; l < LANES; l++) begin
            // Group factor picked by lane index
            exponent[l] <= exponent_t'(factor0) + exponent_t'(factor1[l / GROUP_LANES]);
         end
      end
   end

endmodule

//--- logic/lane_shifter.sv
`timescale 1ns/1ns

module lane_shifter (
   input  cbfp2_pkg::exponent_t   exponent [cbfp2_pkg::LANES],
   input  cbfp2_pkg::sample_t     din_r    [cbfp2_pkg::LANES],
   input  cbfp2_pkg::sample_t     din_q    [cbfp2_pkg::LANES],
   output cbfp2_pkg::out_sample_t dout_r   [cbfp2_pkg::LANES],
   output cbfp2_pkg::out_sample_t dout_q   [cbfp2_pkg::LANES]
);

   import cbfp2_pkg::*;

   // Shift around the norm point, keep the low OUT_W bits
   function automatic out_sample_t renorm(input sample_t s, input exponent_t e);
      sample_t shifted;
      if (e >= ZERO_LIMIT) begin
         shifted = '0;
      end else if (e > NORM_POINT) begin
         shifted = s >>> (e - NORM_POINT);  // Sign kept
      end else begin
         shifted = s <<< (NORM_POINT - e);
      end
      return shifted[OUT_W-1:0];
   endfunction

   ////////////////////
   // Per-lane renormalizers
   ////////////////////

   for (genvar l = 0; l < LANES; l++) begin : g_lane
      assign dout_r[l] = renorm(din_r[l], exponent[l]);
      assign dout_q[l] = renorm(din_q[l], exponent[l]);  // Same exponent as R
   end

endmodule

//--- logic/cbfp2.sv
`timescale 1ns/1ns

module cbfp2 (
   input  logic                   clk,
   input  logic                   rst_n,

   input  logic                   push_idx1,
   input  cbfp2_pkg::factor_t     push_data_idx1,
   input  logic                   push_idx2,
   input  cbfp2_pkg::factor_t     push_data_idx2 [cbfp2_pkg::GROUPS],
   input  logic                   pop,

   input  cbfp2_pkg::sample_t     din_r  [cbfp2_pkg::LANES],
   input  cbfp2_pkg::sample_t     din_q  [cbfp2_pkg::LANES],
   output cbfp2_pkg::out_sample_t dout_r [cbfp2_pkg::LANES],
   output cbfp2_pkg::out_sample_t dout_q [cbfp2_pkg::LANES]
);

   import cbfp2_pkg::*;

   factor_t   factor0;
   factor_t   factor1  [GROUPS];
   exponent_t exponent [LANES];

   ////////////////////
   // Factor stores
   ////////////////////

   // One factor per 64 samples, shared by two pops
   stage0_factor_store u_stage0_store (
      .clk            (clk),
      .rst_n          (rst_n),
      .push_idx1      (push_idx1),
      .push_data_idx1 (push_data_idx1),
      .pop            (pop),
      .factor0        (factor0)
   );

   stage1_factor_store u_stage1_store (
      .clk            (clk),
      .rst_n          (rst_n),
      .push_idx2      (push_idx2),
      .push_data_idx2 (push_data_idx2),
      .pop            (pop),
      .factor1        (factor1)
   );

   ////////////////////
   // Exponent sum
   ////////////////////

   exponent_sum u_exponent_sum (
      .clk      (clk),
      .rst_n    (rst_n),
      .pop      (pop),
      .factor0  (factor0),
      .factor1  (factor1),
      .exponent (exponent)
   );

   ////////////////////
   // Lane shifters
   ////////////////////

   // Zero latency from din
   lane_shifter u_lane_shifter (
      .exponent (exponent),
      .din_r    (din_r),
      .din_q    (din_q),
      .dout_r   (dout_r),
      .dout_q   (dout_q)
   );

endmodule

//--- verif/cbfp2_checker.sv
`timescale 1ns/1ns

module cbfp2_checker (
   input  logic                   clk,
   input  logic                   rst_n,
   input  logic                   push_idx1,
   input  cbfp2_pkg::factor_t     push_data_idx1,
   input  logic                   push_idx2,
   input  cbfp2_pkg::factor_t     push_data_idx2 [cbfp2_pkg::GROUPS],
   input  logic                   pop,
   input  cbfp2_pkg::sample_t     din_r  [cbfp2_pkg::LANES],
   input  cbfp2_pkg::sample_t     din_q  [cbfp2_pkg::LANES],
   input  cbfp2_pkg::out_sample_t dout_r [cbfp2_pkg::LANES],
   input  cbfp2_pkg::out_sample_t dout_q [cbfp2_pkg::LANES],
   output int                     mismatch_count,
   output int                     timeout_count,
   output int                     checked_cycles
);

   import cbfp2_pkg::*;

   localparam int CHECK_DELAY   = 90;  // Just ahead of the next rising edge
   localparam int RESET_TIMEOUT = 100;

   typedef logic [GROUPS*FACTOR_W-1:0] quad_t;

   factor_t   q0 [$];  // Stage 0 factors waiting
   quad_t     q1 [$];
   logic      phase0;
   logic      pop_d;
   factor_t   m_f0;
   factor_t   m_f1  [GROUPS];
   exponent_t m_exp [LANES];

   // Expected output sample from the renormalization rules
   function automatic out_sample_t ref_renorm(input sample_t s, input exponent_t e);
      int value;
      int scaled;
      value = s;
      if (e >= ZERO_LIMIT) begin
         scaled = 0;
      end else if (e > NORM_POINT) begin
         scaled = value >>> (e - NORM_POINT);
      end else begin
         scaled = value * (1 << (NORM_POINT - e));
      end
      return out_sample_t'(scaled);  // Keep the low 13 bits
   endfunction

   function automatic quad_t pack_groups(input factor_t f [GROUPS]);
      quad_t q;
      for (int g = 0; g < GROUPS; g++) begin
         q[g*FACTOR_W +: FACTOR_W] = f[g];
      end
      return q;
   endfunction

   ////////////////////
   // Queue and exponent model
   ////////////////////

   always @(posedge clk) begin : model
      logic  full0;
      logic  full1;
      quad_t head;
      if (!rst_n) begin
         q0.delete();
         q1.delete();
         phase0 <= 1'b0;
         pop_d  <= 1'b0;
         m_f0   <= '0;
         for (int g = 0; g < GROUPS; g++) begin
            m_f1[g] <= '0;
         end
         for (int l = 0; l < LANES; l++) begin
            m_exp[l] <= '0;
         end
      end else begin
         full0 = (q0.size() >= STORE_DEPTH);
         full1 = (q1.size() >= STORE_DEPTH);
         if (pop) begin
            if (phase0) begin
               phase0 <= 1'b0;  // Second pop of a pair
            end else if (q0.size() != 0) begin
               m_f0   <= q0.pop_front();
               phase0 <= 1'b1;
            end
            if (q1.size() != 0) begin
               head = q1.pop_front();
               for (int g = 0; g < GROUPS; g++) begin
                  m_f1[g] <= head[g*FACTOR_W +: FACTOR_W];
               end
            end
         end
         if (push_idx1 && !full0) begin
            q0.push_back(push_data_idx1);
         end
         if (push_idx2 && !full1) begin
            q1.push_back(pack_groups(push_data_idx2));
         end
         pop_d <= pop;
         if (pop_d) begin
            for (int l = 0; l < LANES; l++) begin
               m_exp[l] <= exponent_t'(m_f0) + exponent_t'(m_f1[l / GROUP_LANES]);
            end
         end
      end
   end

   ////////////////////
   // Comparison
   ////////////////////

   task automatic compare_lanes();
      out_sample_t exp_r;
      out_sample_t exp_q;
      for (int l = 0; l < LANES; l++) begin
         exp_r = ref_renorm(din_r[l], m_exp[l]);
         exp_q = ref_renorm(din_q[l], m_exp[l]);
         if (dout_r[l] !== exp_r) begin
            $display("ERROR dout_r lane %0d: expected %h, actual %h", l, exp_r, dout_r[l]);
            mismatch_count++;
         end
         if (dout_q[l] !== exp_q) begin
            $display("ERROR dout_q lane %0d: expected %h, actual %h", l, exp_q, dout_q[l]);
            mismatch_count++;
         end
      end
      checked_cycles++;
   endtask

   initial begin
      int waited;
      mismatch_count = 0;
      timeout_count  = 0;
      checked_cycles = 0;
      waited         = 0;
      while (rst_n !== 1'b1 && waited < RESET_TIMEOUT) begin
         @(posedge clk);
         waited++;
      end
      if (rst_n !== 1'b1) begin
         $display("Reset was never released, no outputs were checked");
         timeout_count++;
      end else begin
         forever begin
            @(posedge clk);
            #(CHECK_DELAY);
            if (rst_n) begin
               compare_lanes();
            end
         end
      end
   end

endmodule

//--- verif/tb_cbfp2.sv
`timescale 1ns/1ns

module tb_cbfp2;

   import cbfp2_pkg::*;

   localparam int          CLK_PERIOD   = 100;
   localparam int          DRIVE_DELAY  = 10;
   localparam int          RESET_CYCLES = 16;
   localparam logic [31:0] SEED         = 32'h44c7_3adf;

   typedef logic [GROUPS*FACTOR_W-1:0] quad_t;

   logic        clk;
   logic        rst_n;
   logic        push_idx1;
   factor_t     push_data_idx1;
   logic        push_idx2;
   factor_t     push_data_idx2 [GROUPS];
   logic        pop;
   sample_t     din_r  [LANES];
   sample_t     din_q  [LANES];
   out_sample_t dout_r [LANES];
   out_sample_t dout_q [LANES];
   int          mismatch_count;
   int          timeout_count;
   int          checked_cycles;

   cbfp2 uut (
      .clk            (clk),
      .rst_n          (rst_n),
      .push_idx1      (push_idx1),
      .push_data_idx1 (push_data_idx1),
      .push_idx2      (push_idx2),
      .push_data_idx2 (push_data_idx2),
      .pop            (pop),
      .din_r          (din_r),
      .din_q          (din_q),
      .dout_r         (dout_r),
      .dout_q         (dout_q)
   );

   cbfp2_checker chk (
      .clk            (clk),
      .rst_n          (rst_n),
      .push_idx1      (push_idx1),
      .push_data_idx1 (push_data_idx1),
      .push_idx2      (push_idx2),
      .push_data_idx2 (push_data_idx2),
      .pop            (pop),
      .din_r          (din_r),
      .din_q          (din_q),
      .dout_r         (dout_r),
      .dout_q         (dout_q),
      .mismatch_count (mismatch_count),
      .timeout_count  (timeout_count),
      .checked_cycles (checked_cycles)
   );

   initial begin
      clk = 1'b0;
      forever #(CLK_PERIOD / 2) clk = ~clk;
   end

   ////////////////////
   // Stimulus helpers
   ////////////////////

   function automatic quad_t make_quad(input int g0, input int g1, input int g2, input int g3);
      return {factor_t'(g3), factor_t'(g2), factor_t'(g1), factor_t'(g0)};
   endfunction

   task automatic randomize_din();
      for (int l = 0; l < LANES; l++) begin
         din_r[l] = sample_t'($urandom);
         din_q[l] = sample_t'($urandom);
      end
   endtask

   // Drive one cycle of inputs, then move to just after the next edge
   task automatic drive_cycle(input logic p1, input factor_t f0, input logic p2,
                              input quad_t quad, input logic pp);
      push_idx1      = p1;
      push_data_idx1 = f0;
      push_idx2      = p2;
      for (int g = 0; g < GROUPS; g++) begin
         push_data_idx2[g] = quad[g*FACTOR_W +: FACTOR_W];
      end
      pop = pp;
      randomize_din();
      @(posedge clk);
      #(DRIVE_DELAY);
   endtask

   task automatic idle_cycles(input int n);
      repeat (n) drive_cycle(1'b0, '0, 1'b0, '0, 1'b0);
   endtask

   task automatic pop_and_settle();
      drive_cycle(1'b0, '0, 1'b0, '0, 1'b1);
      idle_cycles(3);  // New exponents land two edges later
   endtask

   ////////////////////
   // Test sequence
   ////////////////////

   initial begin
      void'($urandom(SEED));
      rst_n          = 1'b0;
      push_idx1      = 1'b0;
      push_data_idx1 = '0;
      push_idx2      = 1'b0;
      for (int g = 0; g < GROUPS; g++) begin
         push_data_idx2[g] = '0;
      end
      pop = 1'b0;
      randomize_din();
      repeat (RESET_CYCLES) @(posedge clk);
      #(DRIVE_DELAY);
      rst_n = 1'b1;

      idle_cycles(8);  // Exponents still zero

      // Stage 0 pairing with random factors
      drive_cycle(1'b1, factor_t'($urandom), 1'b1, quad_t'($urandom), 1'b0);
      drive_cycle(1'b1, factor_t'($urandom), 1'b1, quad_t'($urandom), 1'b0);
      drive_cycle(1'b0, '0, 1'b1, quad_t'($urandom), 1'b0);
      drive_cycle(1'b0, '0, 1'b1, quad_t'($urandom), 1'b0);
      repeat (4) pop_and_settle();

      // Sums 4 9 12 22, 23 31 5 9, then 13 22 23 44, 16 20 15 13
      drive_cycle(1'b1, 5'd4, 1'b1, make_quad(0, 5, 8, 18), 1'b0);
      drive_cycle(1'b1, 5'd13, 1'b1, make_quad(19, 27, 1, 5), 1'b0);
      drive_cycle(1'b0, '0, 1'b1, make_quad(0, 9, 10, 31), 1'b0);
      drive_cycle(1'b0, '0, 1'b1, make_quad(3, 7, 2, 0), 1'b0);
      repeat (4) pop_and_settle();

      // Back to back pops
      drive_cycle(1'b1, factor_t'($urandom), 1'b1, quad_t'($urandom), 1'b0);
      drive_cycle(1'b1, factor_t'($urandom), 1'b1, quad_t'($urandom), 1'b0);
      drive_cycle(1'b0, '0, 1'b1, quad_t'($urandom), 1'b0);
      drive_cycle(1'b0, '0, 1'b1, quad_t'($urandom), 1'b0);
      repeat (4) drive_cycle(1'b0, '0, 1'b0, '0, 1'b1);
      idle_cycles(4);

      // Both stores empty here
      pop_and_settle();
      drive_cycle(1'b1, factor_t'($urandom), 1'b1, quad_t'($urandom), 1'b0);
      pop_and_settle();
      pop_and_settle();
      idle_cycles(4);

      $display("Check summary: %0d cycles compared, %0d mismatches, %0d timeouts",
               checked_cycles, mismatch_count, timeout_count);
      if (mismatch_count == 0 && timeout_count == 0 && checked_cycles > 0) begin
         $display("TESTBENCH PASSED");
      end else begin
         if (checked_cycles == 0) begin
            $display("No output cycle was ever compared");
         end
         $display("TESTBENCH FAILED");
      end
      $finish;
   end

endmodule

//--- list.f
logic/cbfp2_pkg.sv
logic/stage0_factor_store.sv
logic/stage1_factor_store.sv
logic/exponent_sum.sv
logic/lane_shifter.sv
logic/cbfp2.sv
verif/cbfp2_checker.sv
verif/tb_cbfp2.sv

//--- Makefile
# Verilator build and run for the CBFP output stage testbench

VERILATOR ?= verilator
TOP       ?= tb_cbfp2
FILE_LIST ?= list.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
PASS_TEXT ?= TESTBENCH PASSED
VFLAGS    ?= --binary --timing -Wno-fatal

SIM_BIN = $(BUILD_DIR)/V$(TOP)

.PHONY: all compile run clean

all: run

compile: $(SIM_BIN)

$(SIM_BIN): $(FILE_LIST) $(shell cat $(FILE_LIST))
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -Mdir $(BUILD_DIR) \
		-o V$(TOP) -f $(FILE_LIST)

run: compile
	./$(SIM_BIN) > $(LOG) 2>&1; cat $(LOG)
	@if grep -q "$(PASS_TEXT)" $(LOG); then \
		echo "Simulation passed"; \
	else \
		echo "Simulation failed, see $(LOG)"; \
		exit 1; \
	fi

clean:
	rm -rf $(BUILD_DIR) $(LOG)
